/* Bender.yml */
package:
  name: rv32i_core

sources:
  - common/rv_isa_pkg.sv
  - common/core_pkg.sv
  - common/dec_if.sv
  - idu/idu.sv
  - hw/ifu.sv
  - hw/regfile.sv
  - hw/exu.sv
  - hw/core_top.sv
  - target: simulation
    files:
      - sim/tb_core.sv

/* common/core_pkg.sv */
package core_pkg;

    localparam int XLEN = 32;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // where the second operand or the final result comes from.
    typedef enum logic [1:0] {
        SEL_REG = 2'b00,
        SEL_IMM = 2'b01,
        SEL_PC4 = 2'b10,
        SEL_PCI = 2'b11
    } src_sel_e;

    typedef enum logic [2:0] {
        S_REQ,
        S_WAIT_ACK,
        S_WAIT_REL,
        S_EXEC,
        S_HALT
    } fetch_state_e;

endpackage

/* common/dec_if.sv */
`timescale 1ns/1ns

interface dec_if;

    logic [core_pkg::XLEN-1:0] imm;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                rd;
    core_pkg::alu_op_e         alu_op;
    core_pkg::src_sel_e        src_sel;
    logic                      wen;
    logic                      is_lui;
    logic                      branch;
    logic                      jal;
    logic                      jalr;
    logic                      ebreak;

    modport idu (
        output imm, rs1, rs2, rd, alu_op, src_sel,
        output wen, is_lui, branch, jal, jalr, ebreak
    );

    modport exu (
        input imm, rs1, rs2, rd, alu_op, src_sel,
        input wen, is_lui, branch, jal, jalr, ebreak
    );

    // fetch only needs to know when to stop.
    modport ifu (
        input ebreak
    );

endinterface

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction word.
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // lowest bit of each instruction field.
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // funct3 for OP and OP-IMM.
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;

    // funct3 for BRANCH.
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    // funct7 that turns ADD into SUB and SRL into SRA.
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    localparam logic [31:0] INSN_EBREAK = 32'h0010_0073;

endpackage

/* flist.f */
common/rv_isa_pkg.sv
common/core_pkg.sv
common/dec_if.sv
idu/idu.sv
hw/ifu.sv
hw/regfile.sv
hw/exu.sv
hw/core_top.sv
sim/tb_core.sv

/* hw/core_top.sv */
`timescale 1ns/1ns

module core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        i_clock,
    input  logic        i_rst_n,
    output logic        o_imem_req,
    output logic [31:0] o_imem_addr,
    input  logic        i_imem_ack,
    input  logic [31:0] i_imem_data,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_rd,
    output logic [31:0] o_wb_data,
    output logic        o_halt
);

    dec_if dec ();

    logic [31:0]               insn;
    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] next_pc;
    logic                      exec;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic                      we;
    logic [4:0]                rd;
    logic [core_pkg::XLEN-1:0] wd;

    ifu #(
        .RESET_PC (RESET_PC)
    ) u_ifu (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .o_imem_req  (o_imem_req),
        .o_imem_addr (o_imem_addr),
        .i_imem_ack  (i_imem_ack),
        .i_imem_data (i_imem_data),
        .o_insn      (insn),
        .o_pc        (pc),
        .o_exec      (exec),
        .i_next_pc   (next_pc),
        .o_halt      (o_halt),
        .dec         (dec.ifu)
    );

    idu u_idu (
        .i_insn (insn),
        .dec    (dec.idu)
    );

    regfile u_regfile (
        .i_clock    (i_clock),
        .i_rs1      (dec.rs1),
        .i_rs2      (dec.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (we),
        .i_rd       (rd),
        .i_wd       (wd)
    );

    exu u_exu (
        .i_pc          (pc),
        .i_insn_funct3 (insn[rv_isa_pkg::FUNCT3_LSB +: 3]),
        .i_exec        (exec),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .dec           (dec.exu),
        .o_next_pc     (next_pc),
        .o_we          (we),
        .o_rd          (rd),
        .o_wd          (wd)
    );

    // retire port mirrors the register file write port.
    assign o_wb_valid = exec;
    assign o_wb_rd    = rd;
    assign o_wb_data  = wd;

endmodule

/* hw/exu.sv */
`timescale 1ns/1ns

module exu (
    input  logic [core_pkg::XLEN-1:0] i_pc,
    input  logic [2:0]                i_insn_funct3,
    input  logic                      i_exec,
    input  logic [core_pkg::XLEN-1:0] i_rs1_data,
    input  logic [core_pkg::XLEN-1:0] i_rs2_data,
    dec_if.exu                        dec,
    output logic [core_pkg::XLEN-1:0] o_next_pc,
    output logic                      o_we,
    output logic [4:0]                o_rd,
    output logic [core_pkg::XLEN-1:0] o_wd
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_res;
    logic [core_pkg::XLEN-1:0] pc_plus4;
    logic [core_pkg::XLEN-1:0] pc_plus_imm;
    logic [core_pkg::XLEN-1:0] jalr_target;
    logic [4:0]                shamt;
    logic                      eq;
    logic                      lt;
    logic                      ltu;
    logic                      cond;

    // LUI is x0 + imm.
    assign op_a  = dec.is_lui ? '0 : i_rs1_data;
    assign op_b  = (dec.src_sel == core_pkg::SEL_IMM) ? dec.imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            core_pkg::ADD:  alu_res = op_a + op_b;
            core_pkg::SUB:  alu_res = op_a - op_b;
            core_pkg::SLL:  alu_res = op_a << shamt;
            core_pkg::SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::SLTU: alu_res = {31'd0, op_a < op_b};
            core_pkg::XOR:  alu_res = op_a ^ op_b;
            core_pkg::SRL:  alu_res = op_a >> shamt;
            core_pkg::SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            core_pkg::OR:   alu_res = op_a | op_b;
            default:        alu_res = op_a & op_b;
        endcase
    end

    assign pc_plus4    = i_pc + 32'd4;
    assign pc_plus_imm = i_pc + dec.imm;
    assign jalr_target = (i_rs1_data + dec.imm) & ~32'd1;

    assign eq  = (i_rs1_data == i_rs2_data);
    assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign ltu = (i_rs1_data < i_rs2_data);

    always_comb begin
        case (i_insn_funct3)
            rv_isa_pkg::BEQ:  cond = eq;
            rv_isa_pkg::BNE:  cond = !eq;
            rv_isa_pkg::BLT:  cond = lt;
            rv_isa_pkg::BGE:  cond = !lt;
            rv_isa_pkg::BLTU: cond = ltu;
            rv_isa_pkg::BGEU: cond = !ltu;
            default:          cond = 1'b0;
        endcase
    end

    always_comb begin
        if ((dec.branch && cond) || dec.jal) begin
            o_next_pc = pc_plus_imm;
        end else if (dec.jalr) begin
            o_next_pc = jalr_target;
        end else begin
            o_next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (dec.src_sel)
            core_pkg::SEL_PC4: o_wd = pc_plus4;
            core_pkg::SEL_PCI: o_wd = pc_plus_imm;
            default:           o_wd = alu_res;
        endcase
    end

    assign o_we = dec.wen && i_exec;
    assign o_rd = dec.wen ? dec.rd : 5'd0;

endmodule

/* hw/ifu.sv */
`timescale 1ns/1ns

module ifu #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    output logic                      o_imem_req,
    output logic [core_pkg::XLEN-1:0] o_imem_addr,
    input  logic                      i_imem_ack,
    input  logic [31:0]               i_imem_data,
    output logic [31:0]               o_insn,
    output logic [core_pkg::XLEN-1:0] o_pc,
    output logic                      o_exec,
    input  logic [core_pkg::XLEN-1:0] i_next_pc,
    output logic                      o_halt,
    dec_if.ifu                        dec
);

    core_pkg::fetch_state_e    state;
    logic [core_pkg::XLEN-1:0] pc_q;
    logic [31:0]               insn_q;
    logic                      req_q;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state <= core_pkg::S_REQ;
            pc_q  <= RESET_PC;
            req_q <= 1'b0;
        end else begin
            case (state)
                core_pkg::S_REQ: begin
                    req_q <= 1'b1;
                    state <= core_pkg::S_WAIT_ACK;
                end
                core_pkg::S_WAIT_ACK: begin
                    if (i_imem_ack) begin
                        req_q <= 1'b0;
                        state <= core_pkg::S_WAIT_REL;
                    end
                end
                core_pkg::S_WAIT_REL: begin
                    // memory must release ack before the next request.
                    if (!i_imem_ack) begin
                        state <= core_pkg::S_EXEC;
                    end
                end
                core_pkg::S_EXEC: begin
                    if (dec.ebreak) begin
                        state <= core_pkg::S_HALT;
                    end else begin
                        pc_q  <= i_next_pc;
                        req_q <= 1'b1;
                        state <= core_pkg::S_WAIT_ACK;
                    end
                end
                core_pkg::S_HALT: begin
                    state <= core_pkg::S_HALT;
                end
                default: begin
                    req_q <= 1'b0;
                    state <= core_pkg::S_REQ;
                end
            endcase
        end
    end

    // instruction register, captured with the ack.
    always_ff @(posedge i_clock) begin
        if (state == core_pkg::S_WAIT_ACK && i_imem_ack) begin
            insn_q <= i_imem_data;
        end
    end

    assign o_imem_req  = req_q;
    assign o_imem_addr = pc_q;
    assign o_insn      = insn_q;
    assign o_pc        = pc_q;
    assign o_exec      = (state == core_pkg::S_EXEC);
    assign o_halt      = (state == core_pkg::S_HALT);

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic                      i_clock,
    input  logic [4:0]                i_rs1,
    input  logic [4:0]                i_rs2,
    output logic [core_pkg::XLEN-1:0] o_rs1_data,
    output logic [core_pkg::XLEN-1:0] o_rs2_data,
    input  logic                      i_we,
    input  logic [4:0]                i_rd,
    input  logic [core_pkg::XLEN-1:0] i_wd
);

    // x0 has no storage.
    logic [core_pkg::XLEN-1:0] regs [31:1];

    always_ff @(posedge i_clock) begin
        if (i_we && i_rd != 5'd0) begin
            regs[i_rd] <= i_wd;
        end
    end

    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

/* idu/idu.sv */
`timescale 1ns/1ns

module idu (
    input  logic [31:0] i_insn,
    dec_if.idu          dec
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [4:0]          rd_field;
    logic [4:0]          rs1_field;
    logic [4:0]          rs2_field;
    logic                alt;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode    = rv_isa_pkg::opcode_e'(i_insn[6:0]);
    assign funct3    = i_insn[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7    = i_insn[rv_isa_pkg::FUNCT7_LSB +: 7];
    assign rd_field  = i_insn[rv_isa_pkg::RD_LSB +: 5];
    assign rs1_field = i_insn[rv_isa_pkg::RS1_LSB +: 5];
    assign rs2_field = i_insn[rv_isa_pkg::RS2_LSB +: 5];
    assign alt       = (funct7 == rv_isa_pkg::FUNCT7_ALT);

    assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
    assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    always_comb begin
        dec.imm     = '0;
        dec.rs1     = 5'd0;
        dec.rs2     = 5'd0;
        dec.rd      = 5'd0;
        dec.src_sel = core_pkg::SEL_REG;
        dec.wen     = 1'b0;

        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                dec.imm     = imm_i;
                dec.rs1     = rs1_field;
                dec.rd      = rd_field;
                dec.src_sel = core_pkg::SEL_IMM;
                dec.wen     = 1'b1;
            end
            rv_isa_pkg::OP: begin
                dec.rs1 = rs1_field;
                dec.rs2 = rs2_field;
                dec.rd  = rd_field;
                dec.wen = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                dec.imm     = imm_u;
                dec.rd      = rd_field;
                dec.src_sel = core_pkg::SEL_IMM;
                dec.wen     = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                dec.imm     = imm_u;
                dec.rd      = rd_field;
                dec.src_sel = core_pkg::SEL_PCI;
                dec.wen     = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                dec.imm     = imm_j;
                dec.rd      = rd_field;
                dec.src_sel = core_pkg::SEL_PC4;
                dec.wen     = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                dec.imm     = imm_i;
                dec.rs1     = rs1_field;
                dec.rd      = rd_field;
                dec.src_sel = core_pkg::SEL_PC4;
                dec.wen     = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                dec.imm = imm_b;
                dec.rs1 = rs1_field;
                dec.rs2 = rs2_field;
            end
            // recognised but not executed, the immediate is still formed.
            rv_isa_pkg::LOAD:  dec.imm = imm_i;
            rv_isa_pkg::STORE: dec.imm = imm_s;
            default: begin
                dec.imm = '0;
            end
        endcase
    end

    always_comb begin
        dec.alu_op = core_pkg::ADD;
        if (opcode == rv_isa_pkg::OP || opcode == rv_isa_pkg::OP_IMM) begin
            case (funct3)
                rv_isa_pkg::ADD_SUB: begin
                    // OP-IMM has no SUB, bit 30 is part of the immediate there.
                    if (opcode == rv_isa_pkg::OP && alt) begin
                        dec.alu_op = core_pkg::SUB;
                    end
                end
                rv_isa_pkg::SLL:     dec.alu_op = core_pkg::SLL;
                rv_isa_pkg::SLT:     dec.alu_op = core_pkg::SLT;
                rv_isa_pkg::SLTU:    dec.alu_op = core_pkg::SLTU;
                rv_isa_pkg::XOR:     dec.alu_op = core_pkg::XOR;
                rv_isa_pkg::SRL_SRA: dec.alu_op = alt ? core_pkg::SRA : core_pkg::SRL;
                rv_isa_pkg::OR:      dec.alu_op = core_pkg::OR;
                default:             dec.alu_op = core_pkg::AND;
            endcase
        end else if (opcode == rv_isa_pkg::BRANCH) begin
            // branch outcome comes from the comparator in exu.
            dec.alu_op = funct3[2] ? core_pkg::SLTU : core_pkg::SLT;
        end
    end

    assign dec.is_lui = (opcode == rv_isa_pkg::LUI);
    assign dec.branch = (opcode == rv_isa_pkg::BRANCH);
    assign dec.jal    = (opcode == rv_isa_pkg::JAL);
    assign dec.jalr   = (opcode == rv_isa_pkg::JALR);
    assign dec.ebreak = (i_insn == rv_isa_pkg::INSN_EBREAK);

endmodule

/* sim/tb_core.sv */
`timescale 1ns/1ns

module tb_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int HALT_CYCLES  = 20;
    localparam int SEED         = 68;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] insn;
        logic [4:0]  rd;
        logic [31:0] data;
    } row_t;

    logic        i_clock;
    logic        i_rst_n;
    logic        o_imem_req;
    logic [31:0] o_imem_addr;
    logic        i_imem_ack;
    logic [31:0] i_imem_data;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_halt;

    row_t        program_q[$];
    logic [31:0] imem [0:63];
    bit          table_ready;
    int          value_errors;
    int          proto_errors;

    core_top #(
        .RESET_PC (32'h0000_0000)
    ) DUT (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .o_imem_req  (o_imem_req),
        .o_imem_addr (o_imem_addr),
        .i_imem_ack  (i_imem_ack),
        .i_imem_data (i_imem_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_halt      (o_halt)
    );

    initial begin
        i_clock     = 1'b0;
        i_rst_n     = 1'b0;
        i_imem_ack  = 1'b0;
        i_imem_data = 32'h0;
        forever begin
            #(CLK_PERIOD / 2) i_clock = ~i_clock;
        end
    end

    // instruction encoders for the RV32I formats.
    function automatic logic [31:0] op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // words that are never part of the program.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'h5A5A_0000 ^ {addr[15:0], addr[31:16]} ^ addr;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:8] == 24'd0) begin
            return imem[addr[7:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic add_row(input logic [31:0] addr, input logic [31:0] insn,
                           input logic [4:0] rd, input logic [31:0] data);
        row_t r;
        r.addr = addr;
        r.insn = insn;
        r.rd   = rd;
        r.data = data;
        program_q.push_back(r);
        imem[addr[7:2]] = insn;
    endtask

    task automatic build_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = fill_word(i * 4);
        end
        add_row(32'h00, op_imm_word(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005);
        add_row(32'h04, op_imm_word(3'b000, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD);
        add_row(32'h08, op_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0002);
        add_row(32'h0C, op_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0000_0008);
        add_row(32'h10, op_word(7'h20, 3'b000, 5'd5, 5'd2, 5'd1), 5'd5, 32'hFFFF_FFF8);
        add_row(32'h14, op_imm_word(3'b101, 5'd6, 5'd5, 12'h402), 5'd6, 32'hFFFF_FFFE);
        add_row(32'h18, op_imm_word(3'b101, 5'd7, 5'd5, 12'h004), 5'd7, 32'h0FFF_FFFF);
        add_row(32'h1C, op_imm_word(3'b001, 5'd8, 5'd1, 12'h003), 5'd8, 32'h0000_0028);
        add_row(32'h20, op_word(7'h00, 3'b010, 5'd9, 5'd2, 5'd1), 5'd9, 32'h0000_0001);
        add_row(32'h24, op_word(7'h00, 3'b011, 5'd10, 5'd2, 5'd1), 5'd10, 32'h0000_0000);
        add_row(32'h28, op_imm_word(3'b010, 5'd11, 5'd2, 12'hFFE), 5'd11, 32'h0000_0001);
        add_row(32'h2C, op_imm_word(3'b011, 5'd12, 5'd1, 12'hFFF), 5'd12, 32'h0000_0001);
        add_row(32'h30, op_imm_word(3'b100, 5'd13, 5'd1, 12'h0F0), 5'd13, 32'h0000_00F5);
        add_row(32'h34, op_word(7'h00, 3'b110, 5'd14, 5'd1, 5'd8), 5'd14, 32'h0000_002D);
        add_row(32'h38, op_imm_word(3'b111, 5'd15, 5'd2, 12'h07F), 5'd15, 32'h0000_007D);
        add_row(32'h3C, op_word(7'h00, 3'b001, 5'd16, 5'd1, 5'd1), 5'd16, 32'h0000_00A0);
        add_row(32'h40, op_word(7'h20, 3'b101, 5'd17, 5'd5, 5'd1), 5'd17, 32'hFFFF_FFFF);
        add_row(32'h44, op_word(7'h00, 3'b101, 5'd18, 5'd2, 5'd1), 5'd18, 32'h07FF_FFFF);
        add_row(32'h48, op_word(7'h00, 3'b100, 5'd19, 5'd1, 5'd2), 5'd19, 32'hFFFF_FFF8);
        add_row(32'h4C, op_word(7'h00, 3'b111, 5'd20, 5'd1, 5'd2), 5'd20, 32'h0000_0005);
        add_row(32'h50, upper_word(7'b0110111, 5'd21, 20'h12345), 5'd21, 32'h1234_5000);
        add_row(32'h54, upper_word(7'b0010111, 5'd22, 20'h00001), 5'd22, 32'h0000_1054);
        // x0 takes the write but must still read back as zero.
        add_row(32'h58, op_imm_word(3'b000, 5'd0, 5'd0, 12'd7), 5'd0, 32'h0);
        add_row(32'h5C, op_word(7'h00, 3'b000, 5'd23, 5'd0, 5'd1), 5'd23, 32'h0000_0005);
        // each branch is taken and then not taken with x1 = 5, x2 = -3 and x20 = 5.
        add_row(32'h60, branch_word(3'b000, 5'd1, 5'd20, 13'd8), 5'd0, 32'h0);
        add_row(32'h68, branch_word(3'b000, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'h6C, branch_word(3'b001, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'h74, branch_word(3'b001, 5'd1, 5'd20, 13'd8), 5'd0, 32'h0);
        add_row(32'h78, branch_word(3'b100, 5'd2, 5'd1, 13'd8), 5'd0, 32'h0);
        add_row(32'h80, branch_word(3'b100, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'h84, branch_word(3'b101, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'h8C, branch_word(3'b101, 5'd2, 5'd1, 13'd8), 5'd0, 32'h0);
        add_row(32'h90, branch_word(3'b110, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'h98, branch_word(3'b110, 5'd2, 5'd1, 13'd8), 5'd0, 32'h0);
        add_row(32'h9C, branch_word(3'b111, 5'd2, 5'd1, 13'd8), 5'd0, 32'h0);
        add_row(32'hA4, branch_word(3'b111, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0);
        add_row(32'hA8, jal_word(5'd24, 21'd24), 5'd24, 32'h0000_00AC);
        // 5 + 0xAC is odd so the target drops bit 0.
        add_row(32'hC0, jalr_word(5'd25, 5'd1, 12'h0AC), 5'd25, 32'h0000_00C4);
        add_row(32'hB0, {12'h000, 5'd0, 3'b010, 5'd26, 7'b0000011}, 5'd0, 32'h0);
        add_row(32'hB4, op_imm_word(3'b000, 5'd27, 5'd24, 12'd0), 5'd27, 32'h0000_00AC);
        add_row(32'hB8, 32'h0010_0073, 5'd0, 32'h0);
    endtask

    task automatic check_addr(input int row, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR o_imem_addr row %0d: expected %08h, got %08h", row, exp, act);
        end
    endtask

    task automatic check_rd(input int row, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR o_wb_rd row %0d: expected %02h, got %02h", row, exp, act);
        end
    endtask

    task automatic check_data(input int row, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR o_wb_data row %0d: expected %08h, got %08h", row, exp, act);
        end
    endtask

    task automatic check_halt(input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR o_halt: expected %h, got %h", exp, act);
        end
    endtask

    task automatic report_counts();
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, proto_errors);
    endtask

    // slow memory with random ack and release delays.
    initial begin : memory_responder
        int unsigned delay;
        void'($urandom(SEED));
        wait (i_rst_n);
        forever begin
            @(negedge i_clock);
            if (o_imem_req && !i_imem_ack) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge i_clock);
                i_imem_data = fetch_word(o_imem_addr);
                i_imem_ack  = 1'b1;
                while (o_imem_req) begin
                    @(negedge i_clock);
                end
                delay = $urandom % 4;
                repeat (delay) @(negedge i_clock);
                i_imem_ack = 1'b0;
            end
        end
    end

    // four-phase order is sampled just after the rising edge.
    initial begin : handshake_monitor
        logic prev_req;
        prev_req = 1'b0;
        forever begin
            @(posedge i_clock);
            #1;
            if (i_rst_n && o_imem_req && !prev_req && i_imem_ack) begin
                proto_errors++;
                $display("request raised at %0t while the previous ack was still high", $time);
            end
            if (i_rst_n && !o_imem_req && prev_req && !i_imem_ack) begin
                proto_errors++;
                $display("request dropped at %0t before any ack was seen", $time);
            end
            prev_req = o_imem_req;
        end
    end

    initial begin : watchdog
        int unsigned limit_cycles;
        wait (table_ready);
        limit_cycles = program_q.size() * 12 + RESET_CYCLES + HALT_CYCLES;
        repeat (limit_cycles) @(posedge i_clock);
        $display("timeout: the program did not finish within %0d cycles", limit_cycles);
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_sequence
        row_t r;
        build_program();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_rst_n = 1'b1;

        for (int i = 0; i < program_q.size(); i++) begin
            r = program_q[i];
            while (!o_imem_req) begin
                @(posedge i_clock);
                #1;
            end
            check_addr(i, r.addr, o_imem_addr);
            while (!o_wb_valid) begin
                @(posedge i_clock);
                #1;
            end
            check_halt(1'b0, o_halt);
            check_rd(i, r.rd, o_wb_rd);
            if (r.rd != 5'd0) begin
                check_data(i, r.data, o_wb_data);
            end
            @(posedge i_clock);
            #1;
        end

        // the last row is EBREAK.
        check_halt(1'b1, o_halt);
        repeat (HALT_CYCLES) begin
            if (o_imem_req || o_wb_valid) begin
                proto_errors++;
                $display("core kept running after EBREAK at %0t", $time);
            end
            @(posedge i_clock);
            #1;
        end

        report_counts();
        if ((value_errors + proto_errors) == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
